/* Bender.yml */
package:
  name: rhythm_game

sources:
  - hdl/rhythmPkg.sv
  - hdl/noteChart.sv
  - hdl/laneTracker.sv
  - hdl/gameControl.sv
  - hdl/laneRenderer.sv
  - hdl/scoreDisplay.sv
  - hdl/rhythmGameTop.sv
  - target: test
    files:
      - verification/rhythmGameTb.sv

/* filelist.f */
hdl/rhythmPkg.sv
hdl/noteChart.sv
hdl/laneTracker.sv
hdl/gameControl.sv
hdl/laneRenderer.sv
hdl/scoreDisplay.sv
hdl/rhythmGameTop.sv
verification/rhythmGameTb.sv

/* hdl/gameControl.sv */
`timescale 1ns/1ps

module gameControl (
	input  logic DIV_CLK,
	input  logic reset,
	input  logic start,
	input  logic pause,
	input  logic frameTick,
	input  logic [rhythmPkg::LANE_COUNT-1:0] laneHit,
	output logic stepEnable,
	output rhythmPkg::scoreWord_u score
);
	import rhythmPkg::*;

	logic playState;                            // low is idle
	logic [1:0] hitCount;

	// one game step per frame tick while playing and not paused
	assign stepEnable = frameTick && playState && !pause;

	assign hitCount = laneHit[0] + laneHit[1] + laneHit[2];

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			playState <= 1'b0;
			score <= '0;
		end
		else if (!playState)
		begin
			score <= '0;                        // idle keeps the board clear
			if (frameTick && start)
				playState <= 1'b1;
		end
		else if (stepEnable)
			score.count <= score.count + hitCount;
	end

	//////////////////////////////
	scoreNeverDrops: assert property (@(posedge DIV_CLK) disable iff (reset)
		playState && $past(playState) |-> score.count >= $past(score.count));

endmodule

/* hdl/laneRenderer.sv */
`timescale 1ns/1ps

module laneRenderer (
	input  logic DIV_CLK,
	input  logic reset,
	input  logic [rhythmPkg::POS_W-1:0] pixelX,
	input  logic [rhythmPkg::POS_W-1:0] pixelY,
	input  logic displayArea,
	input  logic [rhythmPkg::LANE_COUNT-1:0] laneButtons,
	input  logic [rhythmPkg::SLOT_COUNT*rhythmPkg::POS_W-1:0] slotPos0,
	input  logic [rhythmPkg::SLOT_COUNT-1:0] slotActive0,
	input  logic [rhythmPkg::SLOT_COUNT*rhythmPkg::POS_W-1:0] slotPos1,
	input  logic [rhythmPkg::SLOT_COUNT-1:0] slotActive1,
	input  logic [rhythmPkg::SLOT_COUNT*rhythmPkg::POS_W-1:0] slotPos2,
	input  logic [rhythmPkg::SLOT_COUNT-1:0] slotActive2,
	output logic vgaRed,
	output logic vgaGreen,
	output logic vgaBlue
);
	import rhythmPkg::*;

	logic [LANE_COUNT-1:0][SLOT_COUNT*POS_W-1:0] lanePos;
	logic [LANE_COUNT-1:0][SLOT_COUNT-1:0] laneActive;
	logic [LANE_COUNT-1:0] noteHit;
	logic [LANE_COUNT-1:0] barHit;

	assign lanePos = {slotPos2, slotPos1, slotPos0};
	assign laneActive = {slotActive2, slotActive1, slotActive0};

	always_comb
	begin
		logic [POS_W-1:0] notePos;
		logic inCols;
		noteHit = '0;
		barHit = '0;
		for (int l = 0; l < LANE_COUNT; l++)
		begin
			inCols = pixelX >= LANE_LEFT[l] && pixelX <= LANE_RIGHT[l];
			for (int s = 0; s < SLOT_COUNT; s++)
			begin
				notePos = lanePos[l][s*POS_W +: POS_W];
				// 32-bit sums, so the top edge clamps at row 0 by itself
				if (inCols && laneActive[l][s] && pixelY + NOTE_HALF >= notePos
					&& pixelY <= notePos + NOTE_HALF)
					noteHit[l] = 1'b1;
			end
			barHit[l] = inCols && laneButtons[l] && pixelY >= BAR_TOP && pixelY <= BAR_BOTTOM;
		end
	end

	//////////////////////////////
	// a held button draws a white bar, notes only their own colour
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			vgaRed <= 1'b0;
			vgaGreen <= 1'b0;
			vgaBlue <= 1'b0;
		end
		else
		begin
			vgaRed <= displayArea && (noteHit[0] || |barHit);
			vgaGreen <= displayArea && (noteHit[1] || |barHit);
			vgaBlue <= displayArea && (noteHit[2] || |barHit);
		end
	end

endmodule

/* hdl/laneTracker.sv */
`timescale 1ns/1ps

module laneTracker (
	input  logic DIV_CLK,
	input  logic reset,
	input  logic stepEnable,
	input  logic spawn,
	input  logic button,
	output logic [rhythmPkg::SLOT_COUNT*rhythmPkg::POS_W-1:0] slotPos,
	output logic [rhythmPkg::SLOT_COUNT-1:0] slotActive,
	output logic laneHit
);
	import rhythmPkg::*;

	logic [SLOT_COUNT-1:0][POS_W-1:0] pos;
	logic [SLOT_COUNT-1:0] active;
	logic [SLOT_COUNT-1:0] claimSlot;           // one-hot, the slot a new note goes into
	logic [SLOT_COUNT-1:0] inWindow;

	assign slotPos = pos;
	assign slotActive = active;

	// lowest clear bit of active, zero when every slot is busy
	assign claimSlot = ~active & (active + 1'b1);

	//////////////////////////////
	// hit window test on the positions before this step moves them
	always_comb
	begin
		for (int i = 0; i < SLOT_COUNT; i++)
			inWindow[i] = active[i] && pos[i] >= HIT_LOW && pos[i] <= HIT_HIGH;
	end

	assign laneHit = stepEnable && button && |inWindow;

	//////////////////////////////
	// falling, freeing and spawning
	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			pos <= '0;
			active <= '0;
		end
		else if (stepEnable)
		begin
			for (int i = 0; i < SLOT_COUNT; i++)
			begin
				if (active[i])
				begin
					if (pos[i] > EXIT_ROW)
					begin
						active[i] <= 1'b0;     // off the bottom
						pos[i] <= '0;
					end
					else
						pos[i] <= pos[i] + 1'b1;
				end
				else if (spawn && claimSlot[i])
					active[i] <= 1'b1;         // starts at row 0, already held there
			end
		end
	end

	// a freed slot has to come back to row 0 before it can be reused
	for (genvar g = 0; g < SLOT_COUNT; g++)
	begin : gSlotCheck
		idleSlotAtTop: assert property (@(posedge DIV_CLK) disable iff (reset)
			!active[g] |-> pos[g] == '0);
	end

endmodule

/* hdl/noteChart.mem */
// one chart row per line, read with $readmemb
// columns from the left: lane 2 (blue), lane 1 (green), lane 0 (red)
001
010
100
011
000
111
101
001
110
001
001
001
010
100
000
111
011
110
101
000
010
001
100
111

/* hdl/noteChart.sv */
`timescale 1ns/1ps

module noteChart (
	input  logic DIV_CLK,
	input  logic reset,
	input  logic stepEnable,
	output logic [rhythmPkg::LANE_COUNT-1:0] spawnRow
);
	import rhythmPkg::*;

	logic [LANE_COUNT-1:0] chartRom [CHART_LEN];
	logic [SPAWN_INTERVAL_W-1:0] spawnCount;
	logic [CHART_IDX_W-1:0] chartIdx;

	initial $readmemb("hdl/noteChart.mem", chartRom); // bit 0 is lane 0

	// a row is released only on the step where the interval counter wraps to zero
	assign spawnRow = (stepEnable && spawnCount == '0) ? chartRom[chartIdx] : '0;

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
		begin
			spawnCount <= '0;
			chartIdx <= '0;
		end
		else if (stepEnable)
		begin
			spawnCount <= spawnCount + 1'b1;
			if (spawnCount == '0)
				chartIdx <= (chartIdx == CHART_IDX_W'(CHART_LEN - 1)) ? '0 : chartIdx + 1'b1;
		end
	end

	chartIdxInRange: assert property (@(posedge DIV_CLK) disable iff (reset)
		chartIdx < CHART_LEN);

endmodule

/* hdl/rhythmGameTop.sv */
`timescale 1ns/1ps

module rhythmGameTop (
	input  logic DIV_CLK,
	input  logic reset,
	input  logic start,
	input  logic pause,
	input  logic frameTick,
	input  logic [rhythmPkg::LANE_COUNT-1:0] laneButtons,
	input  logic [rhythmPkg::POS_W-1:0] pixelX,
	input  logic [rhythmPkg::POS_W-1:0] pixelY,
	input  logic displayArea,
	output logic vgaRed,
	output logic vgaGreen,
	output logic vgaBlue,
	output logic [3:0] anodes,
	output logic [6:0] segments
);
	import rhythmPkg::*;

	logic stepEnable;
	logic [LANE_COUNT-1:0] spawnRow;
	logic [LANE_COUNT-1:0] laneHit;
	scoreWord_u score;
	logic [SLOT_COUNT*POS_W-1:0] slotPos0, slotPos1, slotPos2;
	logic [SLOT_COUNT-1:0] slotActive0, slotActive1, slotActive2;

	//////////////////////////////
	gameControl gameControl_i (.DIV_CLK, .reset, .start, .pause, .frameTick, .laneHit,
		.stepEnable, .score);

	noteChart noteChart_i (.DIV_CLK, .reset, .stepEnable, .spawnRow);

	// lane 0 red, lane 1 green, lane 2 blue
	laneTracker lane0Tracker (.DIV_CLK, .reset, .stepEnable, .spawn(spawnRow[0]),
		.button(laneButtons[0]), .slotPos(slotPos0), .slotActive(slotActive0),
		.laneHit(laneHit[0]));
	laneTracker lane1Tracker (.DIV_CLK, .reset, .stepEnable, .spawn(spawnRow[1]),
		.button(laneButtons[1]), .slotPos(slotPos1), .slotActive(slotActive1),
		.laneHit(laneHit[1]));
	laneTracker lane2Tracker (.DIV_CLK, .reset, .stepEnable, .spawn(spawnRow[2]),
		.button(laneButtons[2]), .slotPos(slotPos2), .slotActive(slotActive2),
		.laneHit(laneHit[2]));

	//////////////////////////////
	laneRenderer laneRenderer_i (.DIV_CLK, .reset, .pixelX, .pixelY, .displayArea,
		.laneButtons, .slotPos0, .slotActive0, .slotPos1, .slotActive1, .slotPos2,
		.slotActive2, .vgaRed, .vgaGreen, .vgaBlue);

	scoreDisplay scoreDisplay_i (.DIV_CLK, .reset, .score, .anodes, .segments);

endmodule

/* hdl/rhythmPkg.sv */
package rhythmPkg;

	//////////////////////////////
	// playfield size
	localparam int LANE_COUNT = 3;
	localparam int SLOT_COUNT = 5;                  // notes in flight per lane
	localparam int POS_W = 10;                      // row positions and pixel coordinates

	//////////////////////////////
	// vertical rows of the playfield
	localparam int EXIT_ROW = 490;                  // past this row a note is gone
	localparam int HIT_LOW = 430;
	localparam int HIT_HIGH = 470;
	localparam int NOTE_HALF = 20;
	localparam int BAR_TOP = 410;
	localparam int BAR_BOTTOM = 450;

	// lane columns, entry 0 is the left (red) lane
	localparam logic [LANE_COUNT-1:0][POS_W-1:0] LANE_LEFT = {10'd440, 10'd220, 10'd0};
	localparam logic [LANE_COUNT-1:0][POS_W-1:0] LANE_RIGHT = {10'd639, 10'd419, 10'd199};

	//////////////////////////////
	// chart and display timing
	localparam int SPAWN_INTERVAL_W = 6;            // one chart row per 64 steps
	localparam int CHART_LEN = 24;
	localparam int CHART_IDX_W = $clog2(CHART_LEN);
	localparam int SCAN_W = 16;

	// score as one count, or as the four hex digits shown on the display
	typedef union packed {
		logic [15:0] count;
		logic [3:0][3:0] digit;                     // digit[0] is the low nibble
	} scoreWord_u;

endpackage

/* hdl/scoreDisplay.sv */
`timescale 1ns/1ps

module scoreDisplay (
	input  logic DIV_CLK,
	input  logic reset,
	input  rhythmPkg::scoreWord_u score,
	output logic [3:0] anodes,
	output logic [6:0] segments
);
	import rhythmPkg::*;

	logic [SCAN_W-1:0] scanCount;
	logic [1:0] digitSel;
	logic [3:0] digit;

	always_ff @(posedge DIV_CLK or posedge reset)
	begin
		if (reset)
			scanCount <= '0;
		else
			scanCount <= scanCount + 1'b1;       // free running
	end

	assign digitSel = scanCount[SCAN_W-1 -: 2];
	assign anodes = ~(4'b0001 << digitSel);     // active low
	assign digit = score.digit[digitSel];

	// segments a..g from the msb down with low lighting the segment
	always_comb
	begin
		case (digit)
			4'h0: segments = 7'b0000001;
			4'h1: segments = 7'b1001111;
			4'h2: segments = 7'b0010010;
			4'h3: segments = 7'b0000110;
			4'h4: segments = 7'b1001100;
			4'h5: segments = 7'b0100100;
			4'h6: segments = 7'b0100000;
			4'h7: segments = 7'b0001111;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0000100;
			4'hA: segments = 7'b0001000;
			4'hB: segments = 7'b1100000;  // b
			4'hC: segments = 7'b0110001;
			4'hD: segments = 7'b1000001;  // d
			4'hE: segments = 7'b0110000;
			default: segments = 7'b0111000;  // F
		endcase
	end

	// the lit digit only ever steps on to its neighbour
	scanInOrder: assert property (@(posedge DIV_CLK) disable iff (reset)
		anodes != $past(anodes) |-> anodes == {$past(anodes[2:0]), $past(anodes[3])});

endmodule

/* verification/rhythmGameTb.sv */
`timescale 1ns/1ps

module rhythmGameTb;
	import rhythmPkg::*;

	localparam int IDLE_CYCLES = 40;
	localparam int PLAY_CYCLES = 1520;                 // covers three passes through the window
	localparam int CYCLE_LIMIT = 3 + IDLE_CYCLES + 1 + PLAY_CYCLES + 40;
	// segment patterns a..g from the msb down and active low
	localparam logic [6:0] SEG_TABLE [16] = '{7'h01, 7'h4F, 7'h12, 7'h06, 7'h4C, 7'h24,
		7'h20, 7'h0F, 7'h00, 7'h04, 7'h08, 7'h60, 7'h31, 7'h41, 7'h30, 7'h38};

	logic DIV_CLK, reset, start, pause, frameTick, displayArea;
	logic [LANE_COUNT-1:0] laneButtons;
	logic [POS_W-1:0] pixelX, pixelY;
	logic vgaRed, vgaGreen, vgaBlue;
	logic [3:0] anodes;
	logic [6:0] segments;

	//////////////////////////////
	// reference model state
	logic [LANE_COUNT-1:0] chartModel [CHART_LEN];
	logic modelPlay;
	logic [SPAWN_INTERVAL_W-1:0] modelSpawnCnt;
	int modelIdx;
	int modelPos [LANE_COUNT][SLOT_COUNT];
	logic modelActive [LANE_COUNT][SLOT_COUNT];
	scoreWord_u modelScore;
	logic [SCAN_W-1:0] modelScan;
	logic [LANE_COUNT-1:0] expColour;               // bit 0 is red and bit 2 is blue
	logic [16:0] lfsr = 17'd90940;
	int cycleCount = 0;
	int hitSteps = 0, pausedSteps = 0, notePixels = 0;

	rhythmGameTop dut_i (.*);

	initial
	begin
		DIV_CLK = 1'b0;
		forever #20 DIV_CLK = ~DIV_CLK;
	end

	function automatic logic [16:0] lfsrStep(logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};              // taps 17 and 14
	endfunction

	function automatic int randBits(int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsrStep(lfsr);
			value = (value << 1) | lfsr[0];
		end
		return value;
	endfunction

	function automatic logic noteInWindow(int l);
		for (int s = 0; s < SLOT_COUNT; s++)
			if (modelActive[l][s] && modelPos[l][s] >= HIT_LOW && modelPos[l][s] <= HIT_HIGH)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic logic noteCovers(int l, int x, int y);
		int top;
		if (x < LANE_LEFT[l] || x > LANE_RIGHT[l])
			return 1'b0;
		for (int s = 0; s < SLOT_COUNT; s++)
		begin
			top = (modelPos[l][s] > NOTE_HALF) ? modelPos[l][s] - NOTE_HALF : 0;
			if (modelActive[l][s] && y >= top && y <= modelPos[l][s] + NOTE_HALF)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	function automatic logic barCovers(int l, int x, int y, logic held);
		return held && x >= LANE_LEFT[l] && x <= LANE_RIGHT[l] && y >= BAR_TOP && y <= BAR_BOTTOM;
	endfunction

	task automatic stopWithFailure(string line);
		$display("%s", line);
		$display("tests failed");
		$fatal(1, "stopping at the first error");
	endtask

	//////////////////////////////
	// model steps on the same edge as the DUT from the inputs set at the falling edge
	always @(posedge DIV_CLK or posedge reset)
	begin : modelUpdate
		logic step;
		logic placed;
		logic white;
		logic [LANE_COUNT-1:0] spawnBits;
		logic [LANE_COUNT-1:0] noteBits;
		int hits;
		if (reset)
		begin
			modelPlay <= 1'b0;
			modelSpawnCnt <= '0;
			modelIdx <= 0;
			modelScore <= '0;
			modelScan <= '0;
			expColour <= '0;
			for (int l = 0; l < LANE_COUNT; l++)
				for (int s = 0; s < SLOT_COUNT; s++)
				begin
					modelPos[l][s] <= 0;
					modelActive[l][s] <= 1'b0;
				end
		end
		else
		begin
			step = frameTick && modelPlay && !pause;
			spawnBits = (step && modelSpawnCnt == 0) ? chartModel[modelIdx] : '0;
			hits = 0;
			white = 1'b0;
			for (int l = 0; l < LANE_COUNT; l++)
			begin
				if (step && laneButtons[l] && noteInWindow(l))
					hits++;
				noteBits[l] = noteCovers(l, pixelX, pixelY);
				white = white | barCovers(l, pixelX, pixelY, laneButtons[l]);
			end
			expColour <= displayArea ? (noteBits | {LANE_COUNT{white}}) : '0;
			modelScan <= modelScan + 1'b1;
			if (!modelPlay)
			begin
				modelScore <= '0;
				if (frameTick && start)
					modelPlay <= 1'b1;
			end
			else if (step)
				modelScore.count <= modelScore.count + 16'(hits);
			if (step)
			begin
				modelSpawnCnt <= modelSpawnCnt + 1'b1;
				if (modelSpawnCnt == 0)
					modelIdx <= (modelIdx + 1) % CHART_LEN;
				for (int l = 0; l < LANE_COUNT; l++)
				begin
					placed = 1'b0;
					for (int s = 0; s < SLOT_COUNT; s++)
						if (modelActive[l][s])
						begin
							if (modelPos[l][s] > EXIT_ROW)
							begin
								modelActive[l][s] <= 1'b0;
								modelPos[l][s] <= 0;
							end
							else
								modelPos[l][s] <= modelPos[l][s] + 1;
						end
						else if (spawnBits[l] && !placed)
						begin
							modelActive[l][s] <= 1'b1;     // new note enters at row 0
							placed = 1'b1;
						end
				end
			end
			if (hits > 0)
				hitSteps++;
			if (modelPlay && pause)
				pausedSteps++;
			if (displayArea && noteBits != 0)
				notePixels++;
		end
	end

	//////////////////////////////
	colourCheck: assert property (@(posedge DIV_CLK) disable iff (reset)
		{vgaBlue, vgaGreen, vgaRed} == expColour)
		else stopWithFailure($sformatf("Fail at %0t ns: colours bgr %b, expected %b", $time,
			$sampled({vgaBlue, vgaGreen, vgaRed}), $sampled(expColour)));

	anodeCheck: assert property (@(posedge DIV_CLK) disable iff (reset)
		$countones(anodes) == 3 && !anodes[modelScan[SCAN_W-1 -: 2]])
		else stopWithFailure($sformatf("Fail at %0t ns: anodes %b, scan digit %0d", $time,
			$sampled(anodes), $sampled(modelScan[SCAN_W-1 -: 2])));

	segmentCheck: assert property (@(posedge DIV_CLK) disable iff (reset)
		segments == SEG_TABLE[modelScore.digit[modelScan[SCAN_W-1 -: 2]]])
		else stopWithFailure($sformatf("Fail at %0t ns: segments %b, model score %h", $time,
			$sampled(segments), $sampled(modelScore.count)));

	always @(posedge DIV_CLK)
	begin
		cycleCount++;
		if (cycleCount > CYCLE_LIMIT)
			stopWithFailure($sformatf("timeout: the run went past %0d cycles", CYCLE_LIMIT));
	end

	// one pixel probe per cycle with the lanes taken in turn
	task automatic driveProbe(int c);
		int lane;
		int row;
		lane = c % LANE_COUNT;
		displayArea = randBits(3) != 0;
		pixelX = POS_W'(LANE_LEFT[lane] + randBits(7));
		if (randBits(4) == 0)
			pixelX = 10'd210;                           // gap between lanes 0 and 1
		case (c % 4)
			0:
			begin
				row = 0;
				for (int s = 0; s < SLOT_COUNT; s++)
					if (modelActive[lane][s])
						row = modelPos[lane][s];
				row = row + randBits(6) - 31;            // follows a falling note
			end
			1: row = BAR_TOP - 10 + randBits(6);
			2: row = c % 512;
			default: row = randBits(9);
		endcase
		pixelY = (row < 0) ? '0 : POS_W'(row);
	endtask

	initial
	begin
		reset = 1'b1;
		start = 1'b0;
		pause = 1'b0;
		frameTick = 1'b1;                                // every play cycle is a step
		laneButtons = '0;
		pixelX = '0;
		pixelY = '0;
		displayArea = 1'b0;
		$readmemb("hdl/noteChart.mem", chartModel);
		repeat (3) @(negedge DIV_CLK);
		reset = 1'b0;
		for (int i = 0; i < IDLE_CYCLES; i++)
		begin
			laneButtons = LANE_COUNT'(randBits(3));     // idle presses score nothing
			driveProbe(i);
			@(negedge DIV_CLK);
		end
		start = 1'b1;
		@(negedge DIV_CLK);
		start = 1'b0;
		for (int c = 0; c < PLAY_CYCLES; c++)
		begin
			pause = (c >= 440 && c < 470) || (c >= 1000 && c < 1024);
			if (c % 8 == 0)
				for (int l = 0; l < LANE_COUNT; l++)
					laneButtons[l] = noteInWindow(l) ? randBits(2) != 0 : randBits(2) == 0;
			driveProbe(c);
			@(negedge DIV_CLK);
		end
		if (hitSteps == 0 || pausedSteps == 0 || notePixels == 0)
			stopWithFailure("the stimulus never scored a hit, paused, or drew a note");
		else
		begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule
